//--- common/uart_pkg.sv
package uart_pkg;

    // Data bits per frame, fixed so the frame struct below has a known width
    localparam int DATA_BITS = 8;

    // Oversampling ticks per serial bit
    localparam int OVERSAMPLE = 16;

    // Error flags reported with every received frame
    typedef struct packed {
        logic brk;    // Every sampled bit of the frame was low, stop bits included
        logic parity; // Received parity bit differs from even parity over the data
        logic frame;  // At least one stop bit was sampled low
    } rx_err_t;

    // One FIFO entry, data first and flags in the low bits
    typedef struct packed {
        logic [DATA_BITS-1:0] data; // First received data bit sits in bit 0
        rx_err_t              err;
    } rx_frame_t;

    // Receive control states
    typedef enum logic [1:0] {
        IDLE,    // Waiting for a start edge, sampler held in reset
        RECEIVE, // Sampler gated on and collecting bits
        CHECK,   // One cycle for the frame checker to register the result
        PUSH     // One cycle write strobe into the receive FIFO
    } rx_state_t;

endpackage

//--- hdl/baud_tick_gen.sv
`timescale 1ns/1ps

module baud_tick_gen #(
    parameter int CLKS_PER_TICK = 10
) (
    input  logic Clk,
    input  logic Rst,
    input  logic rx_gate,
    output logic tick
);

    localparam int CNT_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLKS_PER_TICK - 1);

    logic [CNT_W-1:0] cnt; // Clocks left until the next tick

    // A divide ratio below 2 would leave tick stuck high for the whole frame
    if (CLKS_PER_TICK < 2) begin : g_ratio_check
        $error("baud_tick_gen needs CLKS_PER_TICK of at least 2");
    end

    // Counter sits at the reload value while ungated, so the first tick lands
    // exactly CLKS_PER_TICK clocks after the gate rises on the start edge
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            cnt <= RELOAD;
        end else if (!rx_gate) begin
            cnt <= RELOAD;                 // Phase restarts with every frame
        end else if (cnt == '0) begin
            cnt <= RELOAD;                 // Wrap and start the next tick period
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    // Decoded from the count and the gate so it drops in the same cycle as the gate
    assign tick = rx_gate && (cnt == '0);

endmodule

//--- uart_rx/rx_sampler.sv
`timescale 1ns/1ps

module rx_sampler #(
    parameter int STOP_BITS = 2
) (
    input  logic Clk,
    input  logic Rst,
    input  logic rx_line,     // Asynchronous serial input, idle high
    input  logic rx_gate,
    input  logic tick,        // Oversampling tick, only present while gated
    output logic start_seen,
    output logic false_start,
    output logic bits_done,
    output logic [uart_pkg::DATA_BITS+STOP_BITS+1:0] shift_reg
);

    import uart_pkg::*;

    localparam int NUM_BITS = DATA_BITS + STOP_BITS + 2; // Start, data, parity, stop
    localparam int TICK_W   = $clog2(OVERSAMPLE);
    localparam int BIT_W    = $clog2(NUM_BITS + 1);
    localparam logic [TICK_W-1:0] MID_TICK  = TICK_W'(OVERSAMPLE / 2 - 1);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(OVERSAMPLE - 1);
    localparam logic [BIT_W-1:0]  ALL_BITS  = BIT_W'(NUM_BITS);

    logic [1:0]        sync_q;   // Two flop synchronizer, bit 1 is the safe copy
    logic              line_s;
    logic [TICK_W-1:0] tick_cnt; // Tick index within the current bit
    logic [BIT_W-1:0]  bit_cnt;  // Bits still to be sampled
    logic              sample;

    // Reset to the idle level so no start edge is reported out of reset
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], rx_line};
        end
    end

    assign line_s     = sync_q[1];
    assign start_seen = !line_s && !rx_gate; // Only a level, the FSM decides what to do
    assign sample     = tick && (tick_cnt == MID_TICK) && (bit_cnt != '0);

    // Tick and bit counters, both restart whenever the gate is low
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            tick_cnt    <= '0;
            bit_cnt     <= ALL_BITS;
            false_start <= 1'b0;
            bits_done   <= 1'b0;
        end else if (!rx_gate) begin
            tick_cnt    <= '0;
            bit_cnt     <= ALL_BITS;
            false_start <= 1'b0;
            bits_done   <= 1'b0;
        end else begin
            // First sample is the start bit, it has to still be low at mid-bit
            false_start <= sample && (bit_cnt == ALL_BITS) && line_s;
            bits_done   <= sample && (bit_cnt == BIT_W'(1));
            if (tick) begin
                tick_cnt <= (tick_cnt == LAST_TICK) ? '0 : tick_cnt + 1'b1;
            end
            if (sample) begin
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    // Shift left so the start bit ends up in the MSB and the last stop bit in bit 0
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            shift_reg <= '0;
        end else if (!rx_gate) begin
            shift_reg <= '0;
        end else if (sample) begin
            shift_reg <= {shift_reg[NUM_BITS-2:0], line_s};
        end
    end

    // The tick generator has to stop in the same cycle as the gate, or a stale
    // tick would advance the counters of the next frame
    a_no_tick_ungated: assert property (
        @(posedge Clk) disable iff (Rst)
        !rx_gate |-> !tick
    ) else $error("tick while rx_gate is low");

endmodule

//--- uart_rx/rx_fsm.sv
`timescale 1ns/1ps

module rx_fsm (
    input  logic Clk,
    input  logic Rst,
    input  logic start_seen,  // Synchronized line low while the sampler is idle
    input  logic false_start, // Start bit read high at mid-bit
    input  logic bits_done,   // Last stop bit has been sampled
    input  logic fifo_full,
    output logic rx_gate,     // Enables the tick generator and the sampler
    output logic check_en,    // One cycle strobe to the frame checker
    output logic push,        // One cycle write strobe to the FIFO
    output logic rts          // Flow control level towards the sender
);

    import uart_pkg::*;

    rx_state_t state;
    rx_state_t next_state;

    // State register
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Next state decode
    always_comb begin
        next_state = state; // Stay put unless an event moves us on
        case (state)
            IDLE: begin
                // A sender that ignores rts still gets its frame received, the
                // FIFO then drops the write and flags the overflow
                if (start_seen) begin
                    next_state = RECEIVE;
                end
            end
            RECEIVE: begin
                if (false_start) begin
                    next_state = IDLE;   // Glitch on the line, nothing to store
                end else if (bits_done) begin
                    next_state = CHECK;
                end
            end
            CHECK: begin
                next_state = PUSH;       // Checker registers the frame during this cycle
            end
            PUSH: begin
                next_state = IDLE;       // Dropping the gate clears the sampler
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // Moore outputs registered from the next state so they line up with state
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            rx_gate  <= 1'b0;
            check_en <= 1'b0;
            push     <= 1'b0;
        end else begin
            // Gate stays high through CHECK so shift_reg is intact for the checker
            rx_gate  <= (next_state == RECEIVE) || (next_state == CHECK);
            check_en <= (next_state == CHECK);
            push     <= (next_state == PUSH);
        end
    end

    // Ready to send only while idle and there is room for another frame
    assign rts = (state == IDLE) && !fifo_full;

    // The write into the FIFO must come right after the checker strobe, so the
    // registered frame it stores is always the one just checked
    a_push_after_check: assert property (
        @(posedge Clk) disable iff (Rst)
        push |-> (state == PUSH) && $past(state == CHECK) && $past(check_en)
    ) else $error("push outside PUSH or not preceded by CHECK");

    // Sampler events only matter while a frame is being received
    a_done_in_receive: assert property (
        @(posedge Clk) disable iff (Rst)
        bits_done |-> (state == RECEIVE)
    ) else $error("bits_done seen outside RECEIVE");

endmodule

//--- uart_rx/rx_frame_check.sv
`timescale 1ns/1ps

module rx_frame_check #(
    parameter int STOP_BITS = 2
) (
    input  logic                Clk,
    input  logic                Rst,
    input  logic                check_en,  // One cycle strobe from the FSM
    input  logic [uart_pkg::DATA_BITS+STOP_BITS+1:0] shift_reg,
    output uart_pkg::rx_frame_t frame      // Registered result, FIFO write data
);

    import uart_pkg::*;

    localparam int NUM_BITS = DATA_BITS + STOP_BITS + 2;

    logic [DATA_BITS-1:0] data_bits;
    logic                 parity_calc;
    rx_err_t              err_calc;

    // Layout from MSB down is start, data LSB first, parity, then the stop bits
    always_comb begin
        for (int i = 0; i < DATA_BITS; i++) begin
            data_bits[i] = shift_reg[NUM_BITS-2-i]; // First data bit received is bit 0
        end
        parity_calc     = ^data_bits;                    // Even parity over the data
        err_calc.brk    = (shift_reg == '0);             // Line held low for the whole frame
        err_calc.parity = (shift_reg[STOP_BITS] != parity_calc);
        err_calc.frame  = (shift_reg[STOP_BITS-1:0] != '1); // Any stop bit low
    end

    // Result is captured once per frame and held until the next check
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            frame <= '0;
        end else if (check_en) begin
            frame.data <= data_bits;
            frame.err  <= err_calc;
        end
    end

endmodule

//--- hdl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 8
) (
    input  logic Clk,
    input  logic Rst,
    input  logic push,
    input  T     wdata,
    input  logic pop,
    output T     rdata,    // Current head entry, valid while not empty
    output logic empty,
    output logic full,
    output logic overflow  // Sticky until reset
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;   // Entries currently stored
    logic             push_ok;
    logic             pop_ok;

    // Pointers wrap naturally only for a power of two depth
    if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
        $error("sync_fifo needs DEPTH to be a power of two of at least 2");
    end

    assign push_ok = push && !full;  // A push into a full FIFO is dropped
    assign pop_ok  = pop && !empty;  // A pop from an empty FIFO is ignored

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Both or neither leaves the level alone
            endcase
            if (push && full) begin
                overflow <= 1'b1;              // Lost a frame, stored entries stay intact
            end
        end
    end

    // Write port of the storage array
    always_ff @(posedge Clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= wdata;
        end
    end

    assign rdata = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    a_count_bound: assert property (
        @(posedge Clk) disable iff (Rst)
        count <= CNT_W'(DEPTH)
    ) else $error("FIFO count above DEPTH");

endmodule

//--- hdl/uart_rx_top.sv
`timescale 1ns/1ps

module uart_rx_top #(
    parameter int SYSCLOCK_FREQ = 1_600_000,
    parameter int BAUDRATE      = 10_000,
    parameter int STOP_BITS     = 2,
    parameter int FIFO_DEPTH    = 8
) (
    input  logic                Clk,
    input  logic                Rst,
    input  logic                rx_line,  // Serial input, idle high
    input  logic                pop,      // Take the head entry, ignored when empty
    output uart_pkg::rx_frame_t rx_frame, // Head of the receive FIFO
    output logic                empty,
    output logic                full,
    output logic                overflow,
    output logic                rts
);

    import uart_pkg::*;

    // Clocks per oversampling tick
    localparam int CLKS_PER_TICK = SYSCLOCK_FREQ / (OVERSAMPLE * BAUDRATE);

    logic                              rx_gate;
    logic                              tick;
    logic                              start_seen;
    logic                              false_start;
    logic                              bits_done;
    logic                              check_en;
    logic                              push;
    logic [DATA_BITS+STOP_BITS+1:0]    shift_reg;
    rx_frame_t                         frame;

    baud_tick_gen #(
        .CLKS_PER_TICK (CLKS_PER_TICK)
    ) i_tick_gen (
        .Clk     (Clk),
        .Rst     (Rst),
        .rx_gate (rx_gate),
        .tick    (tick)
    );

    rx_sampler #(
        .STOP_BITS (STOP_BITS)
    ) i_sampler (
        .Clk         (Clk),
        .Rst         (Rst),
        .rx_line     (rx_line),
        .rx_gate     (rx_gate),
        .tick        (tick),
        .start_seen  (start_seen),
        .false_start (false_start),
        .bits_done   (bits_done),
        .shift_reg   (shift_reg)
    );

    rx_fsm i_fsm (
        .Clk         (Clk),
        .Rst         (Rst),
        .start_seen  (start_seen),
        .false_start (false_start),
        .bits_done   (bits_done),
        .fifo_full   (full),
        .rx_gate     (rx_gate),
        .check_en    (check_en),
        .push        (push),
        .rts         (rts)
    );

    rx_frame_check #(
        .STOP_BITS (STOP_BITS)
    ) i_frame_check (
        .Clk       (Clk),
        .Rst       (Rst),
        .check_en  (check_en),
        .shift_reg (shift_reg),
        .frame     (frame)
    );

    sync_fifo #(
        .T     (rx_frame_t),
        .DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .Clk      (Clk),
        .Rst      (Rst),
        .push     (push),
        .wdata    (frame),
        .pop      (pop),
        .rdata    (rx_frame),
        .empty    (empty),
        .full     (full),
        .overflow (overflow)
    );

endmodule

//--- tb/tb_uart_tasks.svh
// Compare one DUT value with its expected value and stop at the first difference
task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
    if (actual !== expected) begin
        $display("MISMATCH at %0d ns: %s got 0x%0h expected 0x%0h",
                 $time, what, actual, expected);
        $display("TEST FAILED");
        $fatal(1, "Value mismatch");
    end
endtask

// Bit 0 is the first bit on the line, so the layout is start, data LSB first, parity, stops
function automatic rx_frame_t expected_from_bits(input logic [FRAME_BITS-1:0] bits);
    rx_frame_t            exp;
    logic [DATA_BITS-1:0] data;
    for (int i = 0; i < DATA_BITS; i++) begin
        data[i] = bits[1 + i];
    end
    exp.data       = data;
    exp.err.brk    = (bits == '0);                  // Nothing but zeros on the line
    exp.err.parity = (bits[DATA_BITS + 1] != ^data); // Even parity over the data
    exp.err.frame  = 1'b0;
    for (int j = 0; j < STOP_BITS; j++) begin
        if (!bits[DATA_BITS + 2 + j]) begin
            exp.err.frame = 1'b1; // Any low stop bit
        end
    end
    return exp;
endfunction

// The FIFO keeps the oldest entries and drops what arrives while it is full
task automatic record_expected(input rx_frame_t exp);
    if (model_q.size() < FIFO_DEPTH) begin
        model_q.push_back(exp);
    end else begin
        model_overflow = 1'b1;
    end
endtask

// Random idle time between frames, long enough for a false start to settle
task automatic idle_gap();
    rnd = $random(seed);
    repeat (16 + rnd[5:0]) @(negedge Clk);
endtask

task automatic drive_frame_bits(input logic [FRAME_BITS-1:0] bits);
    for (int i = 0; i < FRAME_BITS; i++) begin
        rx_line = bits[i];
        if (i == 1) begin
            // Receiver has been busy since the start edge
            check_equal(rts, 1'b0, "rts while a frame is received");
        end
        repeat (BIT_CLKS) @(negedge Clk);
    end
    rx_line = 1'b1; // Back to idle
    record_expected(expected_from_bits(bits));
    idle_gap();
endtask

// Only the first stop bit is pulled low, so the line is high again at frame end
task automatic send_frame(input logic [7:0] data, input logic bad_parity,
                          input logic bad_stop);
    logic [FRAME_BITS-1:0] bits;
    bits                    = '1;
    bits[0]                 = 1'b0;
    bits[DATA_BITS:1]       = data;
    bits[DATA_BITS + 1]     = (^data) ^ bad_parity;
    bits[DATA_BITS + 2]     = !bad_stop;
    drive_frame_bits(bits);
endtask

// Line held low for a whole frame time
task automatic send_break();
    drive_frame_bits('0);
endtask

// Three ticks of low level, then idle for two bit times
task automatic send_glitch();
    rx_line = 1'b0;
    repeat (30) @(negedge Clk);
    rx_line = 1'b1;
    repeat (2 * BIT_CLKS) @(negedge Clk);
endtask

task automatic pop_and_check();
    rx_frame_t exp;
    while (empty) @(negedge Clk);
    if (model_q.size() == 0) begin
        $display("The FIFO holds an entry that the model does not expect");
        $display("TEST FAILED");
        $fatal(1, "Unexpected FIFO entry");
    end
    exp = model_q.pop_front();
    check_equal(rx_frame, exp, $sformatf("FIFO entry %0d", pop_cnt));
    pop = 1'b1; // One cycle strobe
    @(negedge Clk);
    pop = 1'b0;
    pop_cnt++;
endtask

//--- tb/tb_uart_rx.sv
`timescale 1ns/1ps

module tb_uart_rx;

    import uart_pkg::*;

    localparam int SYSCLOCK_FREQ  = 1_600_000;
    localparam int BAUDRATE       = 10_000;
    localparam int STOP_BITS      = 2;
    localparam int FIFO_DEPTH     = 8;
    localparam int BIT_CLKS       = SYSCLOCK_FREQ / BAUDRATE; // 160 clocks per serial bit
    localparam int FRAME_BITS     = DATA_BITS + STOP_BITS + 2; // Start, data, parity, stop
    localparam int NUM_GOOD       = 30;
    localparam int NUM_PARITY     = 6;
    localparam int NUM_STOP       = 6;
    localparam int NUM_BURST      = 10;
    // Glitch, break and the frame after the glitch count as frames too
    localparam int NUM_FRAMES     = NUM_GOOD + NUM_PARITY + NUM_STOP + NUM_BURST + 3;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 13 * BIT_CLKS * 3 / 2;

    logic        Clk;
    logic        Rst;
    logic        rx_line;
    logic        pop;
    rx_frame_t   rx_frame;
    logic        empty;
    logic        full;
    logic        overflow;
    logic        rts;
    integer      seed;
    int          cycle_cnt = 0;
    int          pop_cnt;
    logic        model_overflow; // Set once the model sees a frame arrive with no room
    rx_frame_t   model_q[$];     // Entries the FIFO should hold, oldest first
    logic [31:0] rnd;
    logic        flip_parity;    // Random parity choice for the bad stop bit frames

    uart_rx_top #(
        .SYSCLOCK_FREQ (SYSCLOCK_FREQ),
        .BAUDRATE      (BAUDRATE),
        .STOP_BITS     (STOP_BITS),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) i_dut (
        .Clk      (Clk),
        .Rst      (Rst),
        .rx_line  (rx_line),
        .pop      (pop),
        .rx_frame (rx_frame),
        .empty    (empty),
        .full     (full),
        .overflow (overflow),
        .rts      (rts)
    );

    always #10 Clk = ~Clk; // 20 ns period

    `include "tb_uart_tasks.svh"

    // Random data byte from the seeded generator
    function automatic logic [7:0] rand_byte();
        rnd = $random(seed);
        return rnd[7:0];
    endfunction

    // Run limit scaled to the number of frames in the sequence
    always @(posedge Clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    // The sender must be held off for as long as there is no room
    always @(negedge Clk) begin
        if (!Rst && full) begin
            check_equal(rts, 1'b0, "rts while FIFO full");
        end
    end

    initial begin
        Clk            = 1'b0;
        Rst            = 1'b1;
        rx_line        = 1'b1; // Line idles high
        pop            = 1'b0;
        seed           = 32'ha1f7;
        pop_cnt        = 0;
        model_overflow = 1'b0;
        flip_parity    = 1'b0;
        repeat (5) @(posedge Clk);
        @(negedge Clk);
        Rst = 1'b0;

        check_equal(empty, 1'b1, "empty after reset");
        check_equal(full, 1'b0, "full after reset");
        check_equal(overflow, 1'b0, "overflow after reset");
        check_equal(rts, 1'b1, "rts after reset");

        for (int i = 0; i < NUM_GOOD; i++) begin // Clean frames
            send_frame(rand_byte(), 1'b0, 1'b0);
            pop_and_check();
        end

        for (int i = 0; i < NUM_PARITY; i++) begin // Inverted parity bit
            send_frame(rand_byte(), 1'b1, 1'b0);
            pop_and_check();
        end

        // Zero stop bit, with parity picked at random on top
        for (int i = 0; i < NUM_STOP; i++) begin
            rnd         = $random(seed);
            flip_parity = rnd[4];
            send_frame(rand_byte(), flip_parity, 1'b1);
            pop_and_check();
        end

        send_break();
        pop_and_check();

        send_glitch(); // Short low pulse must leave the FIFO untouched
        check_equal(empty, 1'b1, "empty after line glitch");
        send_frame(rand_byte(), 1'b0, 1'b0);
        pop_and_check();
        check_equal(empty, 1'b1, "empty after glitch recovery");

        // Burst into a FIFO nobody drains, the last two frames are lost
        check_equal(overflow, 1'b0, "overflow before burst");
        for (int i = 0; i < NUM_BURST; i++) begin
            send_frame(rand_byte(), 1'b0, 1'b0);
        end
        check_equal(full, 1'b1, "full after burst");
        check_equal(rts, 1'b0, "rts after burst");
        check_equal(overflow, model_overflow, "overflow after burst");
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            pop_and_check();
        end
        check_equal(empty, 1'b1, "empty after draining the burst");
        check_equal(overflow, model_overflow, "overflow stays sticky");

        if (model_q.size() != 0) begin
            $display("The model still expects %0d entries that were never popped", model_q.size());
            $display("TEST FAILED");
            $fatal(1, "Unread model entries");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- build.f
+incdir+tb
common/uart_pkg.sv
hdl/baud_tick_gen.sv
uart_rx/rx_sampler.sv
uart_rx/rx_fsm.sv
uart_rx/rx_frame_check.sv
hdl/sync_fifo.sv
hdl/uart_rx_top.sv
tb/tb_uart_rx.sv

//--- Bender.yml
package:
  name: uart_rx

sources:
  - files:
      - common/uart_pkg.sv
      - hdl/baud_tick_gen.sv
      - uart_rx/rx_sampler.sv
      - uart_rx/rx_fsm.sv
      - uart_rx/rx_frame_check.sv
      - hdl/sync_fifo.sv
      - hdl/uart_rx_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_uart_rx.sv
